// ==== mips_core.f ====
src/mips_isa_pkg.sv
src/core_pkg.sv
src/mips_controller.sv
src/pc_unit.sv
src/reg_file.sv
src/exec_datapath.sv
src/mips_core.sv
tests/core_bus_asserts.sv
tests/mips_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mips_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal -f mips_core.f --top-module mips_core_tb -o sim_mips_core
sim_out=$(./obj_dir/sim_mips_core)
echo "$sim_out"
if echo "$sim_out" | grep -q "TB PASSED"; then
    exit 0
else
    exit 1
fi

// ==== src/core_pkg.sv ====
// control and bus types of the multicycle core; bus is word wide with no byte enables
package core_pkg;

    typedef enum logic [2:0] {
        FETCH,
        FETCH_RELEASE,
        DECODE,
        EXECUTE,
        MEMORY,
        MEM_RELEASE,
        WRITEBACK
    } state_t;

    typedef enum logic [1:0] {
        ALU_SLT = 2'd0,     // signed a < b
        ALU_OR  = 2'd1,
        ALU_SUB = 2'd2,
        ALU_ADD = 2'd3
    } alu_mode_t;

    typedef enum logic [1:0] {
        EXT_ZERO  = 2'd0,   // upper half cleared
        EXT_UPPER = 2'd1,   // immediate in upper half
        EXT_SIGN  = 2'd2
    } ext_mode_t;

    typedef enum logic [1:0] {
        PC_HOLD   = 2'd0,
        PC_STEP   = 2'd1,
        PC_BRANCH = 2'd2,   // taken only with zero set
        PC_JUMP   = 2'd3
    } pc_sel_t;

    typedef struct packed {
        alu_mode_t alu_mode;
        ext_mode_t ext_mode;
        logic      alu_b_imm;
        logic      reg_write;
        logic      wb_from_mem;     // also strobes the load register during MEMORY
        logic      wb_to_rd;
        logic      ir_load;
        logic      bus_data_phase;
        pc_sel_t   pc_sel;
    } ctrl_t;

    typedef struct packed {
        mips_isa_pkg::word_t addr;
        logic                write;
        mips_isa_pkg::word_t wdata;
    } bus_req_t;

    localparam mips_isa_pkg::word_t RESET_PC = 32'h0000_0000;

endpackage

// ==== src/exec_datapath.sv ====
// ALU result recomputes every cycle; operands stay fixed from decode to writeback
module exec_datapath (
    input  logic                   clock,
    input  logic                   reset,
    input  core_pkg::ctrl_t        ctrl,
    input  mips_isa_pkg::word_t    pc,
    input  mips_isa_pkg::word_t    mem_rdata,
    input  mips_isa_pkg::word_t    rs_data,
    input  mips_isa_pkg::word_t    rt_data,
    output mips_isa_pkg::instr_t   instr,
    output logic                   zero,
    output mips_isa_pkg::reg_idx_t wr_idx,
    output mips_isa_pkg::word_t    wr_data,
    output core_pkg::bus_req_t     bus
);

    mips_isa_pkg::instr_t ir;
    mips_isa_pkg::word_t  imm_ext;
    mips_isa_pkg::word_t  alu_b;
    mips_isa_pkg::word_t  alu_out;
    mips_isa_pkg::word_t  alu_q;
    mips_isa_pkg::word_t  load_q;
    logic                 zero_q;

    always_ff @(posedge clock)
    begin
        if (reset)
            ir <= '0;                               // decodes as a no-op
        else if (ctrl.ir_load)
            ir <= mem_rdata;
    end

    always_comb
    begin
        case (ctrl.ext_mode)
            core_pkg::EXT_ZERO:  imm_ext = {16'h0000, ir.i.imm};
            core_pkg::EXT_UPPER: imm_ext = {ir.i.imm, 16'h0000};
            default:             imm_ext = {{16{ir.i.imm[15]}}, ir.i.imm};
        endcase
    end

    assign alu_b = ctrl.alu_b_imm ? imm_ext : rt_data;

    always_comb
    begin
        case (ctrl.alu_mode)
            core_pkg::ALU_SLT: alu_out = ($signed(rs_data) < $signed(alu_b)) ? 32'd1 : 32'd0;
            core_pkg::ALU_OR:  alu_out = rs_data | alu_b;
            core_pkg::ALU_SUB: alu_out = rs_data - alu_b;
            default:           alu_out = rs_data + alu_b;
        endcase
    end

    always_ff @(posedge clock)
    begin
        alu_q  <= alu_out;
        zero_q <= (alu_out == '0);
        if (ctrl.wb_from_mem && ctrl.bus_data_phase)
            load_q <= mem_rdata;                    // lw data on the ack edge
    end

    assign instr   = ir;
    assign zero    = zero_q;
    assign wr_idx  = ctrl.wb_to_rd ? ir.r.rd : ir.r.rt;
    assign wr_data = ctrl.wb_from_mem ? load_q : alu_q;

    assign bus.addr  = ctrl.bus_data_phase ? alu_q : pc;
    assign bus.write = ctrl.bus_data_phase && (ir.i.opcode == mips_isa_pkg::OP_SW);
    assign bus.wdata = rt_data;

endmodule

// ==== src/mips_controller.sv ====
// one instruction in flight; unknown opcodes and R-type funcs retire as no-ops with PC + 4
module mips_controller (
    input  logic                 clock,
    input  logic                 reset,
    input  mips_isa_pkg::instr_t instr,
    input  logic                 mem_ack,
    output logic                 mem_req,
    output core_pkg::ctrl_t      ctrl
);

    core_pkg::state_t    state;
    core_pkg::alu_mode_t dec_alu;
    core_pkg::ext_mode_t dec_ext;
    core_pkg::pc_sel_t   dec_pc;
    logic                dec_b_imm;
    logic                dec_write;
    logic                dec_to_rd;
    logic                dec_mem;
    logic                dec_load;
    logic                handshake_done;

    assign handshake_done = mem_req && mem_ack;

    // opcode decode valid from DECODE until WRITEBACK
    always_comb
    begin
        dec_alu   = core_pkg::ALU_ADD;
        dec_ext   = core_pkg::EXT_SIGN;
        dec_pc    = core_pkg::PC_HOLD;
        dec_b_imm = 1'b1;
        dec_write = 1'b0;
        dec_to_rd = 1'b0;
        dec_mem   = 1'b0;
        dec_load  = 1'b0;
        case (instr.r.opcode)
            mips_isa_pkg::OP_RTYPE:
            begin
                dec_b_imm = 1'b0;
                dec_to_rd = 1'b1;
                case (instr.r.func)
                    mips_isa_pkg::FUNC_ADDU: dec_write = 1'b1;
                    mips_isa_pkg::FUNC_SUBU:
                    begin
                        dec_alu   = core_pkg::ALU_SUB;
                        dec_write = 1'b1;
                    end
                    mips_isa_pkg::FUNC_SLT:
                    begin
                        dec_alu   = core_pkg::ALU_SLT;
                        dec_write = 1'b1;
                    end
                    default: ;                      // no-op func
                endcase
            end
            mips_isa_pkg::OP_ORI:
            begin
                dec_alu   = core_pkg::ALU_OR;
                dec_ext   = core_pkg::EXT_ZERO;
                dec_write = 1'b1;
            end
            mips_isa_pkg::OP_LUI:
            begin
                dec_ext   = core_pkg::EXT_UPPER;   // rs is $zero, so add passes it
                dec_write = 1'b1;
            end
            mips_isa_pkg::OP_ADDIU: dec_write = 1'b1;
            mips_isa_pkg::OP_SLTI:
            begin
                dec_alu   = core_pkg::ALU_SLT;
                dec_write = 1'b1;
            end
            mips_isa_pkg::OP_LW:
            begin
                dec_mem   = 1'b1;
                dec_load  = 1'b1;
                dec_write = 1'b1;
            end
            mips_isa_pkg::OP_SW: dec_mem = 1'b1;  // base + offset
            mips_isa_pkg::OP_BEQ:
            begin
                dec_alu   = core_pkg::ALU_SUB;     // zero flag from rs - rt
                dec_b_imm = 1'b0;
                dec_pc    = core_pkg::PC_BRANCH;
            end
            mips_isa_pkg::OP_J: dec_pc = core_pkg::PC_JUMP;
            default: ;
        endcase
    end

    // phase gating of the decoded controls
    always_comb
    begin
        ctrl           = '0;
        ctrl.alu_mode  = dec_alu;
        ctrl.ext_mode  = dec_ext;
        ctrl.alu_b_imm = dec_b_imm;
        case (state)
            core_pkg::FETCH:
            begin
                ctrl.ir_load = handshake_done;
                if (handshake_done)
                    ctrl.pc_sel = core_pkg::PC_STEP;
            end
            core_pkg::MEMORY:
            begin
                ctrl.bus_data_phase = 1'b1;
                ctrl.wb_from_mem    = dec_load && handshake_done;   // capture load data
            end
            core_pkg::MEM_RELEASE: ctrl.bus_data_phase = 1'b1;      // keep address until ack drops
            core_pkg::WRITEBACK:
            begin
                ctrl.reg_write   = dec_write;
                ctrl.wb_from_mem = dec_load;
                ctrl.wb_to_rd    = dec_to_rd;
                ctrl.pc_sel      = dec_pc;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state   <= core_pkg::FETCH;
            mem_req <= 1'b0;
        end
        else
        begin
            case (state)
                core_pkg::FETCH:
                begin
                    if (handshake_done)
                    begin
                        mem_req <= 1'b0;
                        state   <= core_pkg::FETCH_RELEASE;
                    end
                    else if (!mem_ack)
                        mem_req <= 1'b1;            // first fetch after reset
                end
                core_pkg::FETCH_RELEASE:
                    if (!mem_ack)
                        state <= core_pkg::DECODE;
                core_pkg::DECODE: state <= core_pkg::EXECUTE;
                core_pkg::EXECUTE:
                begin
                    if (dec_mem)
                    begin
                        mem_req <= 1'b1;            // ack already seen low
                        state   <= core_pkg::MEMORY;
                    end
                    else
                        state <= core_pkg::WRITEBACK;
                end
                core_pkg::MEMORY:
                begin
                    if (handshake_done)
                    begin
                        mem_req <= 1'b0;
                        state   <= core_pkg::MEM_RELEASE;
                    end
                end
                core_pkg::MEM_RELEASE:
                    if (!mem_ack)
                        state <= core_pkg::WRITEBACK;
                core_pkg::WRITEBACK:
                begin
                    mem_req <= 1'b1;                // next fetch starts at once
                    state   <= core_pkg::FETCH;
                end
                default: state <= core_pkg::FETCH;
            endcase
        end
    end

endmodule

// ==== src/mips_core.sv ====
// single bus for fetch and data, four-phase req/ack; word accesses only
module mips_core (
    input  logic                clock,
    input  logic                reset,
    input  logic                mem_ack,
    input  mips_isa_pkg::word_t mem_rdata,
    output logic                mem_req,
    output core_pkg::bus_req_t  bus
);

    core_pkg::ctrl_t        ctrl;
    mips_isa_pkg::instr_t   instr;
    mips_isa_pkg::word_t    pc;
    mips_isa_pkg::word_t    rs_data;
    mips_isa_pkg::word_t    rt_data;
    mips_isa_pkg::word_t    wr_data;
    mips_isa_pkg::reg_idx_t wr_idx;
    logic                   zero;

    mips_controller u_controller (
        .clock   (clock),
        .reset   (reset),
        .instr   (instr),
        .mem_ack (mem_ack),
        .mem_req (mem_req),
        .ctrl    (ctrl)
    );

    pc_unit u_pc (
        .clock (clock),
        .reset (reset),
        .ctrl  (ctrl),
        .instr (instr),
        .zero  (zero),
        .pc    (pc)
    );

    reg_file u_regs (
        .clock   (clock),
        .reset   (reset),
        .rs_idx  (instr.r.rs),
        .rt_idx  (instr.r.rt),
        .wr_en   (ctrl.reg_write),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    exec_datapath u_datapath (
        .clock     (clock),
        .reset     (reset),
        .ctrl      (ctrl),
        .pc        (pc),
        .mem_rdata (mem_rdata),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .instr     (instr),
        .zero      (zero),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .bus       (bus)
    );

endmodule

// ==== src/mips_isa_pkg.sv ====
// MIPS32 subset only with R, I and J views of one word; no shifts, no coprocessor or FP encodings
package mips_isa_pkg;

    localparam int OPCODE_W  = 6;
    localparam int REG_IDX_W = 5;
    localparam int SHAMT_W   = 5;
    localparam int FUNC_W    = 6;
    localparam int IMM_W     = 16;
    localparam int INDEX_W   = 26;

    typedef logic [31:0]          word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [FUNC_W-1:0]    func_t;

    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_LUI   = 6'b001111;
    localparam opcode_t OP_ADDIU = 6'b001001;
    localparam opcode_t OP_SLTI  = 6'b001010;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_J     = 6'b000010;

    localparam func_t FUNC_ADDU = 6'b100001;
    localparam func_t FUNC_SUBU = 6'b100011;
    localparam func_t FUNC_SLT  = 6'b101010;

    typedef struct packed {
        opcode_t              opcode;
        reg_idx_t             rs;
        reg_idx_t             rt;
        reg_idx_t             rd;
        logic [SHAMT_W-1:0]   shamt;     // decoded but never used by this core
        func_t                func;
    } instr_r_t;

    typedef struct packed {
        opcode_t              opcode;
        reg_idx_t             rs;
        reg_idx_t             rt;
        logic [IMM_W-1:0]     imm;
    } instr_i_t;

    typedef struct packed {
        opcode_t              opcode;
        logic [INDEX_W-1:0]   index;     // word index inside the 256 MB region
    } instr_j_t;

    // same 32 bits read by format
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_t;

endpackage

// ==== src/pc_unit.sv ====
// PC steps at fetch; branch offset is relative to the already stepped PC, as in MIPS
module pc_unit (
    input  logic                 clock,
    input  logic                 reset,
    input  core_pkg::ctrl_t      ctrl,
    input  mips_isa_pkg::instr_t instr,
    input  logic                 zero,
    output mips_isa_pkg::word_t  pc
);

    mips_isa_pkg::word_t branch_off;
    mips_isa_pkg::word_t jump_target;

    assign branch_off  = {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign jump_target = {pc[31:28], instr.j.index, 2'b00};   // stays in current region

    always_ff @(posedge clock)
    begin
        if (reset)
            pc <= core_pkg::RESET_PC;
        else
        begin
            case (ctrl.pc_sel)
                core_pkg::PC_STEP:
                    pc <= pc + 32'd4;
                core_pkg::PC_BRANCH:
                begin
                    if (zero)                 // beq taken
                        pc <= pc + branch_off;
                end
                core_pkg::PC_JUMP:
                    pc <= jump_target;
                default: ;
            endcase
        end
    end

endmodule

// ==== src/reg_file.sv ====
// 32 x 32 registers, two async reads and one write per clock; $zero never written
module reg_file (
    input  logic                   clock,
    input  logic                   reset,
    input  mips_isa_pkg::reg_idx_t rs_idx,
    input  mips_isa_pkg::reg_idx_t rt_idx,
    input  logic                   wr_en,
    input  mips_isa_pkg::reg_idx_t wr_idx,
    input  mips_isa_pkg::word_t    wr_data,
    output mips_isa_pkg::word_t    rs_data,
    output mips_isa_pkg::word_t    rt_data
);

    mips_isa_pkg::word_t regs [32];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_en && wr_idx != '0)
            regs[wr_idx] <= wr_data;
    end

    // no bypass needed since the write lands before the next decode
    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

// ==== tests/core_bus_asserts.sv ====
// handshake rules sampled on the rising clock; bus checked only while req waits for ack
module core_bus_asserts (
    input logic               clock,
    input logic               reset,
    input logic               mem_req,
    input logic               mem_ack,
    input core_pkg::bus_req_t bus
);
    timeunit 1ns;
    timeprecision 100ps;

    // req stays up until the memory answers
    req_held: assert property (@(posedge clock) disable iff (reset)
        mem_req && !mem_ack |=> mem_req)
        else $error("req dropped before ack");

    // address, write and data frozen while waiting
    bus_stable: assert property (@(posedge clock) disable iff (reset)
        mem_req && !mem_ack |=> $stable(bus))
        else $error("bus request changed while req was high");

    // new request only after ack has fallen
    no_rise_on_ack: assert property (@(posedge clock) disable iff (reset)
        $rose(mem_req) |-> !mem_ack)
        else $error("req rose while ack was high");

    req_low_after_reset: assert property (@(posedge clock)
        reset |=> !mem_req)
        else $error("req high in the cycle after reset");

endmodule

bind mips_core core_bus_asserts u_bus_asserts (
    .clock   (clock),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_ack (mem_ack),
    .bus     (bus)
);

// ==== tests/mips_core_tb.sv ====
// word memory of 1 KB at address 0; ack rise and fall delayed 0..7 cycles by an LFSR; ends after the last store
module mips_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                clock;
    logic                reset;
    logic                mem_ack;
    mips_isa_pkg::word_t mem_rdata;
    logic                mem_req;
    core_pkg::bus_req_t  bus;

    mips_isa_pkg::word_t vec [0:511];
    mips_isa_pkg::word_t mem [0:255];
    int                  n_exp;
    int                  stores_seen;
    int                  value_errors;
    int                  protocol_errors;
    logic                load_done;
    logic                busy;
    logic [2:0]          wait_cnt;
    logic [2:0]          hold_cnt;
    logic [2:0]          delay;
    logic [31:0]         lfsr;
    logic                first_seen;
    logic                was_reset;

    mips_core DUT (
        .clock     (clock),
        .reset     (reset),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .bus       (bus)
    );

    always #2 clock = ~clock;   // 4 ns period

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // three LFSR steps, one bit taken per step
    task automatic draw_delay(output logic [2:0] d);
        for (int b = 0; b < 3; b++)
        begin
            lfsr = lfsr_next(lfsr);
            d[b] = lfsr[0];
        end
    endtask

    task automatic check_store(input core_pkg::bus_req_t exp, input core_pkg::bus_req_t act);
        if (act !== exp)
        begin
            value_errors++;
            $display("** Error at %0t: bus store expected addr %h data %h got addr %h data %h",
                     $time, exp.addr, exp.wdata, act.addr, act.wdata);
        end
    endtask

    task automatic check_word(input string name, input mips_isa_pkg::word_t exp,
                              input mips_isa_pkg::word_t act);
        if (act !== exp)
        begin
            value_errors++;
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // memory model serving one request at a time
    always @(posedge clock)
    begin
        core_pkg::bus_req_t exp;
        was_reset <= reset;
        if (reset)
            mem_ack <= 1'b0;
        else if (mem_ack)
        begin
            if (!mem_req && hold_cnt != 3'd0)
                hold_cnt <= hold_cnt - 3'd1;    // ack lingers after req falls
            else if (!mem_req)
                mem_ack <= 1'b0;
        end
        else if (mem_req && !busy)
        begin
            draw_delay(delay);
            busy     <= 1'b1;
            wait_cnt <= delay;
            if (!first_seen)
            begin
                first_seen = 1'b1;
                check_word("bus.addr of first fetch", core_pkg::RESET_PC, bus.addr);
            end
        end
        else if (mem_req && wait_cnt != 3'd0)
            wait_cnt <= wait_cnt - 3'd1;
        else if (mem_req)
        begin
            draw_delay(delay);
            hold_cnt <= delay;
            busy     <= 1'b0;
            mem_ack  <= 1'b1;
            if (bus.addr[31:10] != '0)
            begin
                protocol_errors++;
                $display("bus address %h lies outside the 1 KB memory", bus.addr);
            end
            mem_rdata <= mem[bus.addr[9:2]];
            if (bus.write)
            begin
                mem[bus.addr[9:2]] <= bus.wdata;
                if (stores_seen >= n_exp)
                begin
                    protocol_errors++;
                    $display("extra store to %h with data %h after the last expected one",
                             bus.addr, bus.wdata);
                end
                else
                begin
                    exp.addr  = vec[257 + 2 * stores_seen];
                    exp.write = 1'b1;
                    exp.wdata = vec[258 + 2 * stores_seen];
                    check_store(exp, bus);
                end
                stores_seen++;
            end
        end
        if (!reset && was_reset && mem_req)
        begin
            protocol_errors++;
            $display("mem_req was high in the cycle after reset");
        end
    end

    // watchdog allowing 40 instructions of 20 cycles per expected store
    initial
    begin
        wait (load_done);
        #(n_exp * 40 * 20 * 4);
        $display("timeout with %0d of %0d expected stores seen", stores_seen, n_exp);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        clock           = 1'b0;
        reset           = 1'b1;
        mem_ack         = 1'b0;
        mem_rdata       = '0;
        busy            = 1'b0;
        wait_cnt        = '0;
        hold_cnt        = '0;
        lfsr            = 32'h3c3a4f0a;
        first_seen      = 1'b0;
        was_reset       = 1'b1;
        stores_seen     = 0;
        value_errors    = 0;
        protocol_errors = 0;
        load_done       = 1'b0;
        for (int i = 0; i < 512; i++)
            vec[i] = {16'hdead, 16'(i)};
        $readmemh("tests/mips_core_vectors.txt", vec);
        for (int i = 0; i < 256; i++)
            mem[i] = vec[i];
        n_exp     = int'(vec[256]);
        load_done = 1'b1;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        wait (stores_seen >= n_exp);
        repeat (100) @(posedge clock);      // catch stores past the end
        $display("value errors %0d, protocol errors %0d, stores %0d of %0d",
                 value_errors, protocol_errors, stores_seen, n_exp);
        if (value_errors == 0 && protocol_errors == 0 && stores_seen == n_exp)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== tests/mips_core_vectors.txt ====
// words 0..255 are the memory image (byte address = index * 4)
// index 256 holds the number of expected stores, then one address and data pair per store
@000
34010005 3402FFF0 3C031234 2404FFFD  // 00: ori ori lui addiu
00242821 00223023 0081382A 2828FFFF  // 10: addu subu slt slti
2889FFFE AC010200 AC020204 AC030208  // 20: slti then stores
AC04020C AC050210 AC060214 AC070218  // 30
AC08021C AC090220 8C0A0100 AC0A0224  // 40: lw preloaded word, sw copy
8C0B0104 AC0B0100 8C0C0100 AC0C0228  // 50: overwrite 0x100, reload it
10220001 AC01022C 10E90002 AC020300  // 60: beq not taken, beq taken
AC030304 AC050230 08000021 AC060308  // 70: j skips two stores
AC06030C FC000000 AC040234 1000FFFF  // 80: no-op, last store, spin
@040
12345678 80000001                    // preloaded data at 0x100
@100
0000000F
00000200 00000005  00000204 0000FFF0  00000208 12340000
0000020C FFFFFFFD  00000210 00000002  00000214 FFFF0015
00000218 00000001  0000021C 00000000  00000220 00000001
00000224 12345678  00000100 80000001  00000228 80000001
0000022C 00000005  00000230 00000002  00000234 FFFFFFFD
